/* rtl/alu_branch.sv */
`default_nettype none
`timescale 1ns/1ns

module alu_branch import rv_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   a,
    input  word_t   b,
    input  word_t   pc,
    input  word_t   imm,
    input  logic    is_branch,
    input  logic    branch_ne,
    input  logic    is_jal,
    output word_t   result,
    output logic    take,
    output word_t   target
);

    logic equal;
    logic less;

    assign equal = (a == b);
    assign less  = ($signed(a) < $signed(b));

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {31'b0, less};
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // BEQ takes on equal, BNE on not equal
    assign take = is_jal | (is_branch & (equal ^ branch_ne));

    // Same adder serves branches and JAL
    assign target = pc + imm;

endmodule

`default_nettype wire

/* rtl/decoder.sv */
`default_nettype none
`timescale 1ns/1ns

module decoder import rv_pkg::*; (
    input  word_t    instr,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_t  alu_op,
    output logic     use_imm,
    output logic     reg_write,
    output logic     is_load,
    output logic     is_store,
    output logic     is_branch,
    output logic     branch_ne,
    output logic     is_jal,
    output logic     uses_rs2
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        // Anything not matched below falls out as a NOP
        rs1       = instr[19:15];
        imm       = {{20{instr[31]}}, instr[31:20]};
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                uses_rs2  = 1'b1;
                case (funct3)
                    3'b000:  alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: begin
                        reg_write = 1'b0;
                        uses_rs2  = 1'b0;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            OPC_LUI: begin
                rs1       = '0;
                imm       = {instr[31:12], 12'b0};
                alu_op    = ALU_PASS_B;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OPC_LOAD: begin
                // Word accesses only
                use_imm   = 1'b1;
                reg_write = (funct3 == 3'b010);
                is_load   = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm  = 1'b1;
                is_store = (funct3 == 3'b010);
                uses_rs2 = 1'b1;
            end
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
                is_branch = (funct3[2:1] == 2'b00);
                branch_ne = funct3[0];
                uses_rs2  = 1'b1;
            end
            OPC_JAL: begin
                rs1 = '0;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
                reg_write = 1'b1;
                is_jal    = 1'b1;
            end
            default: rs1 = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`default_nettype none
`timescale 1ns/1ns

module hazard_unit import rv_pkg::*; (
    input  logic       iack_n,
    input  logic       dack_n,
    input  logic       mreq,
    input  reg_idx_t   id_rs1,
    input  reg_idx_t   id_rs2,
    input  logic       ex_is_load,
    input  reg_idx_t   ex_rd,
    input  reg_idx_t   ex_rs1,
    input  reg_idx_t   ex_rs2,
    input  reg_idx_t   mem_rd,
    input  logic       mem_reg_write,
    input  reg_idx_t   wb_rd,
    input  logic       wb_reg_write,
    input  logic       take,
    output logic       interlock,
    output logic       stall,
    output logic       flush,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b
);

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;

    // Either bus not ready freezes everything
    assign interlock = iack_n | (mreq & dack_n);

    // Load result arrives one stage too late for the next instruction
    assign stall = ex_is_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush = take;

    assign mem_hit_a = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs1;
    assign mem_hit_b = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs2;
    assign wb_hit_a  = wb_reg_write && wb_rd != '0 && wb_rd == ex_rs1;
    assign wb_hit_b  = wb_reg_write && wb_rd != '0 && wb_rd == ex_rs2;

    // Younger producer wins
    assign fwd_a = mem_hit_a ? FWD_MEM : wb_hit_a ? FWD_WB : FWD_REG;
    assign fwd_b = mem_hit_b ? FWD_MEM : wb_hit_b ? FWD_WB : FWD_REG;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none
`timescale 1ns/1ns

module reg_file import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rd1,
    output word_t    rd2,
    input  logic     we,
    input  reg_idx_t wa,
    input  word_t    wd
);

    localparam int IDX_W = $clog2(NUM_REGS);

    word_t            regs [NUM_REGS];
    logic [IDX_W-1:0] ra1;
    logic [IDX_W-1:0] ra2;
    logic [IDX_W-1:0] wa_i;

    // RV32E drops the top index bit
    assign ra1  = rs1[IDX_W-1:0];
    assign ra2  = rs2[IDX_W-1:0];
    assign wa_i = wa[IDX_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa_i != '0) begin
            regs[wa_i] <= wd;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rd1 = (ra1 == '0) ? '0 : (we && wa_i == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa_i == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`default_nettype none
`timescale 1ns/1ns

module rv_core import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic  clk,
    input  logic  arst_n,
    output word_t iad,
    input  word_t idt,
    input  logic  iack_n,
    output word_t dad,
    output word_t dwdata,
    input  word_t drdata,
    output logic  mreq,
    output logic  write,
    input  logic  dack_n
);

    logic interlock, stall, flush;
    logic [1:0] fwd_a, fwd_b;

    word_t pc_q;

    // IF/ID
    logic  id_valid;
    word_t id_instr, id_pc;

    // Decode outputs
    reg_idx_t dec_rs1, dec_rs2, dec_rd, id_rs2;
    word_t    dec_imm, id_rd1, id_rd2;
    alu_op_t  dec_alu_op;
    logic     dec_use_imm, dec_reg_write, dec_is_load, dec_is_store;
    logic     dec_is_branch, dec_branch_ne, dec_is_jal, dec_uses_rs2;

    // ID/EX
    logic     ex_valid, ex_use_imm, ex_reg_write, ex_is_load, ex_is_store;
    logic     ex_is_branch, ex_branch_ne, ex_is_jal;
    alu_op_t  ex_alu_op;
    word_t    ex_pc, ex_imm, ex_rd1, ex_rd2;
    reg_idx_t ex_rs1, ex_rs2, ex_rd;

    // Execute
    word_t op_a, op_b_reg, op_b, ex_pc4, alu_result, target;
    logic  take;

    // EX/MEM
    logic     mem_valid, mem_reg_write, mem_is_load, mem_is_store, mem_is_jal;
    word_t    mem_alu, mem_wdata, mem_pc4, mem_fwd;
    reg_idx_t mem_rd;

    // MEM/WB
    logic     wb_valid, wb_reg_write, wb_is_load, wb_is_jal;
    word_t    wb_alu, wb_rdata, wb_pc4, wb_data;
    reg_idx_t wb_rd;

    assign iad = pc_q;

    decoder i_decoder (
        .instr(id_instr), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm),
        .alu_op(dec_alu_op), .use_imm(dec_use_imm), .reg_write(dec_reg_write),
        .is_load(dec_is_load), .is_store(dec_is_store), .is_branch(dec_is_branch),
        .branch_ne(dec_branch_ne), .is_jal(dec_is_jal), .uses_rs2(dec_uses_rs2)
    );

    // rs2 field only counts as a source when the instruction reads it
    assign id_rs2 = dec_uses_rs2 ? dec_rs2 : '0;

    reg_file #(.NUM_REGS(NUM_REGS)) i_reg_file (
        .clk(clk), .arst_n(arst_n), .rs1(dec_rs1), .rs2(dec_rs2), .rd1(id_rd1),
        .rd2(id_rd2), .we(wb_valid & wb_reg_write), .wa(wb_rd), .wd(wb_data)
    );

    hazard_unit i_hazard_unit (
        .iack_n(iack_n), .dack_n(dack_n), .mreq(mreq), .id_rs1(dec_rs1),
        .id_rs2(id_rs2), .ex_is_load(ex_valid & ex_is_load), .ex_rd(ex_rd),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd),
        .mem_reg_write(mem_valid & mem_reg_write), .wb_rd(wb_rd),
        .wb_reg_write(wb_valid & wb_reg_write), .take(take), .interlock(interlock),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    // Values a younger instruction may pick up
    assign mem_fwd = mem_is_jal ? mem_pc4 : mem_alu;
    assign wb_data = wb_is_load ? wb_rdata : wb_is_jal ? wb_pc4 : wb_alu;

    assign op_a = (fwd_a == FWD_MEM) ? mem_fwd : (fwd_a == FWD_WB) ? wb_data : ex_rd1;
    assign op_b_reg = (fwd_b == FWD_MEM) ? mem_fwd : (fwd_b == FWD_WB) ? wb_data : ex_rd2;
    assign op_b   = ex_use_imm ? ex_imm : op_b_reg;
    assign ex_pc4 = ex_pc + 32'd4;

    alu_branch i_alu_branch (
        .alu_op(ex_alu_op), .a(op_a), .b(op_b), .pc(ex_pc), .imm(ex_imm),
        .is_branch(ex_valid & ex_is_branch), .branch_ne(ex_branch_ne),
        .is_jal(ex_valid & ex_is_jal), .result(alu_result), .take(take), .target(target)
    );

    // Data bus straight from the memory stage
    assign mreq   = mem_valid & (mem_is_load | mem_is_store);
    assign write  = mem_valid & mem_is_store;
    assign dad    = mem_alu;
    assign dwdata = mem_wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q          <= '0;
            id_valid      <= 1'b0;
            id_instr      <= NOP_INSTR;
            ex_valid      <= 1'b0;
            ex_alu_op     <= ALU_ADD;
            ex_use_imm    <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_is_load    <= 1'b0;
            ex_is_store   <= 1'b0;
            ex_is_branch  <= 1'b0;
            ex_branch_ne  <= 1'b0;
            ex_is_jal     <= 1'b0;
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_is_load   <= 1'b0;
            mem_is_store  <= 1'b0;
            mem_is_jal    <= 1'b0;
            wb_valid      <= 1'b0;
            wb_reg_write  <= 1'b0;
            wb_is_load    <= 1'b0;
            wb_is_jal     <= 1'b0;
        end else if (!interlock) begin
            if (flush) begin
                // Redirect and turn the fetched word into a NOP
                pc_q     <= target;
                id_valid <= 1'b0;
                id_instr <= NOP_INSTR;
            end else if (!stall) begin
                pc_q     <= pc_q + 32'd4;
                id_valid <= 1'b1;
                id_instr <= idt;
            end
            // Bubble into execute on stall or flush
            ex_valid      <= id_valid & ~stall & ~flush;
            ex_alu_op     <= dec_alu_op;
            ex_use_imm    <= dec_use_imm;
            ex_reg_write  <= dec_reg_write;
            ex_is_load    <= dec_is_load;
            ex_is_store   <= dec_is_store;
            ex_is_branch  <= dec_is_branch;
            ex_branch_ne  <= dec_branch_ne;
            ex_is_jal     <= dec_is_jal;
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_is_load   <= ex_is_load;
            mem_is_store  <= ex_is_store;
            mem_is_jal    <= ex_is_jal;
            wb_valid      <= mem_valid;
            wb_reg_write  <= mem_reg_write;
            wb_is_load    <= mem_is_load;
            wb_is_jal     <= mem_is_jal;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            if (!stall) begin
                id_pc <= pc_q;
            end
            ex_pc     <= id_pc;
            ex_imm    <= dec_imm;
            ex_rd1    <= id_rd1;
            ex_rd2    <= id_rd2;
            ex_rs1    <= dec_rs1;
            ex_rs2    <= id_rs2;
            ex_rd     <= dec_rd;
            mem_alu   <= alu_result;
            mem_wdata <= op_b_reg;
            mem_pc4   <= ex_pc4;
            mem_rd    <= ex_rd;
            // Load data is valid on the edge that completes the access
            wb_rdata  <= drdata;
            wb_alu    <= mem_alu;
            wb_pc4    <= mem_pc4;
            wb_rd     <= mem_rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Data word and byte address
    typedef logic [31:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // Operand sources in execute
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_MEM = 2'd1;
    localparam logic [1:0] FWD_WB  = 2'd2;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rv_core -f vlog.f -o sim_rv_core

out=$(./obj_dir/sim_rv_core)
echo "$out"
echo "$out" | grep -q "^Test OK$"

/* tb/rv_stim.txt */
# per test: name, word count, store count; then program words (hex), then store pairs
# each store pair is address and data (hex), in the order the stores must happen
alu_ops 17 7
00500093 ffd00113 002081b3 10302023 402081b3 10302223 0020f1b3 10302423
0020e1b3 10302623 0020c1b3 10302823 001121b3 10302a23 0020a1b3 10302c23
0000006f
00000100 00000002 00000104 00000008 00000108 00000005 0000010c fffffffd
00000110 fffffff8 00000114 00000001 00000118 00000000
imm_fwd_x0 11 4
123450b7 6780e093 fff0c113 10102023 10202223 0f00f193 ff018213 10402423
00108013 10002623 0000006f
00000100 12345678 00000104 edcba987 00000108 00000060 0000010c 00000000
load_use 8 3
06400093 10102023 10002103 001101b3 10302223 10402203 10402423 0000006f
00000100 00000064 00000104 000000c8 00000108 000000c8
branch_jal 12 2
00700093 00700113 00208663 10102023 10102223 00209663 10102423 00c002ef
10102623 10102823 10502a23 0000006f
00000108 00000007 00000114 00000020

/* tb/tb_mem.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_mem import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  rand_en,
    input  word_t iad,
    output word_t idt,
    output logic  iack_n,
    input  word_t dad,
    input  word_t dwdata,
    output word_t drdata,
    input  logic  mreq,
    input  logic  write,
    output logic  dack_n
);

    word_t imem [256];
    word_t dmem [256];
    word_t log_addr [64];
    word_t log_data [64];
    int    log_cnt;
    int    i_wait;
    int    d_wait;

    function automatic int next_wait();
        return rand_en ? int'($urandom % 4) : 0;
    endfunction

    assign idt    = imem[iad[9:2]];
    assign drdata = dmem[dad[9:2]];

    // Acknowledge low once the wait count has run out
    assign iack_n = (i_wait != 0);
    assign dack_n = (d_wait != 0);

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            i_wait  <= 0;
            d_wait  <= 0;
            log_cnt <= 0;
            for (int k = 0; k < 256; k++) begin
                dmem[k] <= word_t'(k * 4) ^ 32'hc0de_0000;
            end
        end else begin
            if (i_wait != 0) begin
                i_wait <= i_wait - 1;
            end else begin
                i_wait <= next_wait();
            end
            if (d_wait != 0) begin
                if (mreq) begin
                    d_wait <= d_wait - 1;
                end
            end else if (mreq && !iack_n) begin
                // Access accepted by the core on this edge
                if (write) begin
                    dmem[dad[9:2]]    <= dwdata;
                    log_addr[log_cnt] <= dad;
                    log_data[log_cnt] <= dwdata;
                    log_cnt           <= log_cnt + 1;
                end
                d_wait <= next_wait();
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_rv_core.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_rv_core import rv_pkg::*; ;

    logic  clk = 1'b0;
    logic  arst_n;
    logic  rand_en;
    word_t iad, idt, dad, dwdata, drdata;
    logic  iack_n, mreq, write, dack_n;

    word_t          prog_w [8][64];
    word_t          exp_a [8][16];
    word_t          exp_d [8][16];
    int             n_words [8];
    int             n_stores [8];
    logic [127:0]   names [8];
    int             n_tests = 0;
    int             cycles = 0;
    int             limit = 0;
    int             n_pass = 0;
    int             n_fail = 0;
    bit             test_bad;

    rv_core #(.NUM_REGS(32)) i_dut (
        .clk(clk), .arst_n(arst_n), .iad(iad), .idt(idt), .iack_n(iack_n),
        .dad(dad), .dwdata(dwdata), .drdata(drdata), .mreq(mreq), .write(write),
        .dack_n(dack_n)
    );

    tb_mem i_mem (
        .clk(clk), .arst_n(arst_n), .rand_en(rand_en), .iad(iad), .idt(idt),
        .iack_n(iack_n), .dad(dad), .dwdata(dwdata), .drdata(drdata), .mreq(mreq),
        .write(write), .dack_n(dack_n)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: pipeline made no progress");
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAIL %0s: expected %08h, actual %08h", what, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("FAIL %0s: expected %0d, actual %0d", what, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    r;
        string line;
        fd = $fopen("tb/rv_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/rv_stim.txt");
        end else begin
            // Two comment lines describe the columns
            r = $fgets(line, fd);
            r = $fgets(line, fd);
            while (n_tests < 8 && $fscanf(fd, "%s %d %d", names[n_tests],
                   n_words[n_tests], n_stores[n_tests]) == 3) begin
                for (int k = 0; k < n_words[n_tests]; k++) begin
                    r = $fscanf(fd, "%h", prog_w[n_tests][k]);
                end
                for (int k = 0; k < n_stores[n_tests]; k++) begin
                    r = $fscanf(fd, "%h %h", exp_a[n_tests][k], exp_d[n_tests][k]);
                end
                // Each program runs once without and once with ack delays
                limit += 2 * (16 + 8 * n_words[n_tests] * 4);
                n_tests++;
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t, input bit rnd);
        string tag;
        int    got;
        tag = $sformatf("%0s_%0s", names[t], rnd ? "rand" : "zero");
        test_bad = 1'b0;
        arst_n  <= 1'b0;
        rand_en <= rnd;
        @(posedge clk);
        for (int k = 0; k < 256; k++) begin
            i_mem.imem[k] = NOP_INSTR;
        end
        for (int k = 0; k < n_words[t]; k++) begin
            i_mem.imem[k] = prog_w[t][k];
        end
        repeat (15) @(posedge clk);
        arst_n <= 1'b1;
        while (i_mem.log_cnt < n_stores[t]) begin
            @(posedge clk);
        end
        // Room for any stray store to show up
        repeat (20) @(posedge clk);
        got = i_mem.log_cnt;
        check_count($sformatf("%0s store count", tag), n_stores[t], got);
        for (int k = 0; k < n_stores[t] && k < got; k++) begin
            check_word($sformatf("%0s store %0d addr", tag, k), exp_a[t][k],
                       i_mem.log_addr[k]);
            check_word($sformatf("%0s store %0d data", tag, k), exp_d[t][k],
                       i_mem.log_data[k]);
        end
        if (test_bad) begin
            n_fail++;
            $display("fail %0s", tag);
        end else begin
            n_pass++;
            $display("pass %0s", tag);
        end
    endtask

    initial begin
        void'($urandom(32'hc53a_9627));
        arst_n  <= 1'b0;
        rand_en <= 1'b0;
        load_stimulus();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t, 1'b0);
            run_test(t, 1'b1);
        end
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && n_tests > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/alu_branch.sv
rtl/hazard_unit.sv
rtl/rv_core.sv
tb/tb_mem.sv
tb/tb_rv_core.sv
